//--- common/dbg_uart_macros.svh
// debug telemetry uart parameters
// bit timing, link credit depth and word group sizes
`ifndef DBG_UART_MACROS_SVH
`define DBG_UART_MACROS_SVH

// clock cycles per serial bit, kept short for simulation
`define DBG_CLKS_PER_BIT 8

// depth of every receiving character buffer
`define DBG_CREDITS 4

// telemetry word groups
`define DBG_IMU_WORDS 7
`define DBG_RC_WORDS 11

// word index width, printed as two hex digits
`define DBG_IDX_W 8

`endif

//--- common/dbg_uart_pkg.sv
// debug telemetry uart types
// character link payload, snapshot vectors and fsm encodings
`default_nettype none

`include "dbg_uart_macros.svh"

package dbg_uart_pkg;

	// one text character on a credit link
	typedef struct packed {
		logic [7:0] data; // ascii code
		logic       eol;  // set on the CR ending a line
		logic       eof;  // set on the last character of a group
	} char_t;

	// snapshot groups, word 0 in the low slice
	typedef logic [`DBG_IMU_WORDS-1:0][15:0] imu_vec_t;
	typedef logic [`DBG_RC_WORDS-1:0][15:0]  rc_vec_t;

	typedef enum logic [1:0] {
		FMT_IDLE,
		FMT_EMIT,
		FMT_DONE
	} fmt_state_e;

	typedef enum logic [1:0] {
		SRC_IMU,
		SRC_RC,
		SRC_IDLE
	} merge_src_e;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

endpackage

`default_nettype wire

//--- telem_fmt/telem_formatter.sv
// telemetry formatter
// snapshots a word group and emits hex text lines on a credit link
`timescale 1ns/1ns
`default_nettype none

`include "dbg_uart_macros.svh"

module telem_formatter import dbg_uart_pkg::*; #(
	parameter int NUM_WORDS  = 7,
	parameter int BASE_INDEX = 0
) (
	input  logic                       clk,
	input  logic                       resetn,
	input  logic                       load_i,
	input  logic [NUM_WORDS-1:0][15:0] words_i,
	output char_t                      chr_o,
	output logic                       vld_o,
	input  logic                       crd_i
);

	localparam int IDX_W  = `DBG_IDX_W;
	localparam int CRD_W  = $clog2(`DBG_CREDITS + 1);
	localparam int WCNT_W = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;

	fmt_state_e                 state;
	logic [NUM_WORDS-1:0][15:0] words_q;
	logic [WCNT_W-1:0]          word_cnt;
	logic [2:0]                 char_cnt; // position within the 8 character line
	logic [CRD_W-1:0]           crd_cnt;
	logic [IDX_W-1:0]           idx;
	logic [15:0]                cur_word;
	logic                       last_word;
	logic                       eol;
	logic                       send;

	// nibble to upper case ascii hex digit
	function automatic logic [7:0] hex_char(input logic [3:0] nib);
		if (nib < 4'd10)
			return 8'h30 + {4'h0, nib};
		return 8'h37 + {4'h0, nib}; // 0x37 + 10 = 'A'
	endfunction

	assign idx       = IDX_W'(BASE_INDEX) + IDX_W'(word_cnt);
	assign cur_word  = words_q[word_cnt];
	assign last_word = (word_cnt == WCNT_W'(NUM_WORDS - 1));
	assign eol       = (char_cnt == 3'd7);

	// may only offer a character while credit is left
	assign vld_o = (state == FMT_EMIT) && (crd_cnt != '0);
	assign send  = vld_o;

	always_comb begin
		chr_o.eol = eol;
		chr_o.eof = eol && last_word;
		case (char_cnt)
			3'd0:    chr_o.data = hex_char(idx[7:4]);
			3'd1:    chr_o.data = hex_char(idx[3:0]);
			3'd2:    chr_o.data = hex_char(cur_word[15:12]);
			3'd3:    chr_o.data = hex_char(cur_word[11:8]);
			3'd4:    chr_o.data = hex_char(cur_word[7:4]);
			3'd5:    chr_o.data = hex_char(cur_word[3:0]);
			3'd6:    chr_o.data = 8'h0A; // LF
			default: chr_o.data = 8'h0D; // CR
		endcase
	end

	// snapshot taken in the accepting cycle
	always_ff @(posedge clk) begin
		if (load_i)
			words_q <= words_i;
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state    <= FMT_IDLE;
			word_cnt <= '0;
			char_cnt <= '0;
		end else if (load_i) begin
			state    <= FMT_EMIT;
			word_cnt <= '0;
			char_cnt <= '0;
		end else if (send) begin
			char_cnt <= char_cnt + 3'd1; // wraps to 0 after CR
			if (eol) begin
				if (last_word)
					state <= FMT_DONE; // done level until next load
				else
					word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	// credit count, one down per character sent, one up per credit back
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn)
			crd_cnt <= CRD_W'(`DBG_CREDITS);
		else if (send && !crd_i)
			crd_cnt <= crd_cnt - 1'b1;
		else if (!send && crd_i)
			crd_cnt <= crd_cnt + 1'b1;
	end

endmodule

`default_nettype wire

//--- verilog/line_merger.sv
// line merger
// buffers both formatter streams and forwards imu lines, then rc lines
`timescale 1ns/1ns
`default_nettype none

`include "dbg_uart_macros.svh"

module line_merger import dbg_uart_pkg::*; (
	input  logic  clk,
	input  logic  resetn,
	input  char_t imu_chr_i,
	input  char_t rc_chr_i,
	input  logic  imu_vld_i,
	input  logic  rc_vld_i,
	output logic  imu_crd_o,
	output logic  rc_crd_o,
	output char_t tx_chr_o,
	output logic  tx_vld_o,
	input  logic  tx_crd_i
);

	localparam int DEPTH = `DBG_CREDITS;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	// index 0 is the imu source, 1 the rc source
	logic [1:0]       in_vld;
	char_t            in_chr [2];
	logic [1:0]       pop;
	logic [1:0]       crd_q;
	logic [CNT_W-1:0] fill_s [2];
	char_t            head_s [2];

	merge_src_e       sel;
	logic             cur;
	char_t            head;
	logic [CNT_W-1:0] tx_cnt; // transmitter credits

	assign in_vld    = {rc_vld_i, imu_vld_i};
	assign in_chr[0] = imu_chr_i;
	assign in_chr[1] = rc_chr_i;

	for (genvar s = 0; s < 2; s++) begin : g_src
		char_t            mem [DEPTH];
		logic [PTR_W-1:0] wr_ptr;
		logic [PTR_W-1:0] rd_ptr;
		logic [CNT_W-1:0] fill;

		always_ff @(posedge clk) begin
			if (in_vld[s])
				mem[wr_ptr] <= in_chr[s];
		end

		// no overflow check, the sender's credits bound the fill
		always_ff @(posedge clk or negedge resetn) begin
			if (!resetn) begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				fill   <= '0;
			end else begin
				if (in_vld[s])
					wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
				if (pop[s])
					rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
				if (in_vld[s] && !pop[s])
					fill <= fill + 1'b1;
				else if (!in_vld[s] && pop[s])
					fill <= fill - 1'b1;
			end
		end

		assign fill_s[s] = fill;
		assign head_s[s] = mem[rd_ptr];
	end

	assign cur  = (sel == SRC_RC);
	assign head = head_s[cur];

	assign tx_vld_o = (sel != SRC_IDLE) && (fill_s[cur] != '0) && (tx_cnt != '0);
	assign pop[0]   = tx_vld_o && !cur;
	assign pop[1]   = tx_vld_o && cur;

	// only the rc eof marks the frame end downstream
	always_comb begin
		tx_chr_o = head;
		if (sel == SRC_IMU)
			tx_chr_o.eof = 1'b0;
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			sel <= SRC_IDLE;
		end else begin
			case (sel)
				SRC_IDLE: if (fill_s[0] != '0) sel <= SRC_IMU;
				SRC_IMU:  if (tx_vld_o && head.eof) sel <= SRC_RC;
				SRC_RC:   if (tx_vld_o && head.eof) sel <= SRC_IDLE;
				default:  sel <= SRC_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn)
			tx_cnt <= CNT_W'(`DBG_CREDITS);
		else if (tx_vld_o && !tx_crd_i)
			tx_cnt <= tx_cnt - 1'b1;
		else if (!tx_vld_o && tx_crd_i)
			tx_cnt <= tx_cnt + 1'b1;
	end

	// one credit back per popped entry
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn)
			crd_q <= '0;
		else
			crd_q <= pop;
	end

	assign imu_crd_o = crd_q[0];
	assign rc_crd_o  = crd_q[1];

endmodule

`default_nettype wire

//--- uart_tx/uart_tx.sv
// uart transmitter
// character buffer feeding a fixed 8N1 serializer, credit per character taken
`timescale 1ns/1ns
`default_nettype none

`include "dbg_uart_macros.svh"

module uart_tx import dbg_uart_pkg::*; (
	input  logic  clk,
	input  logic  resetn,
	input  char_t chr_i,
	input  logic  vld_i,
	output logic  crd_o,
	output logic  sout_o,
	output logic  frame_done_o
);

	localparam int DEPTH = `DBG_CREDITS;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int CLKS  = `DBG_CLKS_PER_BIT;
	localparam int CLK_W = (CLKS > 1) ? $clog2(CLKS) : 1;

	char_t            mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] fill;

	tx_state_e        state;
	logic [CLK_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shreg;
	logic             sh_eof;
	logic             tick;
	logic             take;

	assign tick = (clk_cnt == CLK_W'(CLKS - 1)); // last cycle of a bit
	// next character loads when idle or right at the end of a stop bit
	assign take = (fill != '0) && ((state == TX_IDLE) || (state == TX_STOP && tick));

	always_ff @(posedge clk) begin
		if (vld_i)
			mem[wr_ptr] <= chr_i;
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (vld_i)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (take)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (vld_i && !take)
				fill <= fill + 1'b1;
			else if (!vld_i && take)
				fill <= fill - 1'b1;
		end
	end

	// shift register, lsb goes out first
	always_ff @(posedge clk) begin
		if (take) begin
			shreg  <= mem[rd_ptr].data;
			sh_eof <= mem[rd_ptr].eof;
		end else if (state == TX_DATA && tick) begin
			shreg <= shreg >> 1;
		end
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state   <= TX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else if (take) begin
			state   <= TX_START;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else begin
			if (state == TX_IDLE || tick)
				clk_cnt <= '0;
			else
				clk_cnt <= clk_cnt + 1'b1;
			case (state)
				TX_START: if (tick) state <= TX_DATA;
				TX_DATA: begin
					if (tick) begin
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= TX_STOP;
					end
				end
				TX_STOP: if (tick) state <= TX_IDLE;
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			crd_o        <= 1'b0;
			frame_done_o <= 1'b0;
		end else begin
			crd_o        <= take; // slot freed in the buffer
			frame_done_o <= (state == TX_STOP) && tick && sh_eof;
		end
	end

	always_comb begin
		case (state)
			TX_START: sout_o = 1'b0;
			TX_DATA:  sout_o = shreg[0];
			default:  sout_o = 1'b1; // idle and stop level
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/dbg_uart_top.sv
// debug telemetry uart top
// start handshake, two formatters, line merger and 8N1 transmitter
`timescale 1ns/1ns
`default_nettype none

`include "dbg_uart_macros.svh"

module dbg_uart_top import dbg_uart_pkg::*; (
	input  logic     clk,
	input  logic     resetn,
	input  logic     start_i,
	input  imu_vec_t imu_words_i,
	input  rc_vec_t  rc_words_i,
	output logic     sout_o,
	output logic     busy_o,
	output logic     frame_done_o
);

	logic  start_acc;
	logic  busy_q;

	char_t imu_chr;
	char_t rc_chr;
	char_t tx_chr;
	logic  imu_vld, imu_crd;
	logic  rc_vld, rc_crd;
	logic  tx_vld, tx_crd;

	// busy drops in the frame_done cycle so a new start is taken at once
	assign busy_o    = busy_q && !frame_done_o;
	assign start_acc = start_i && !busy_o;

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn)
			busy_q <= 1'b0;
		else if (start_acc)
			busy_q <= 1'b1;
		else if (frame_done_o)
			busy_q <= 1'b0;
	end

	telem_formatter #(
		.NUM_WORDS  (`DBG_IMU_WORDS),
		.BASE_INDEX (0)
	) u_imu_fmt (
		.clk     (clk),
		.resetn  (resetn),
		.load_i  (start_acc),
		.words_i (imu_words_i),
		.chr_o   (imu_chr),
		.vld_o   (imu_vld),
		.crd_i   (imu_crd)
	);

	telem_formatter #(
		.NUM_WORDS  (`DBG_RC_WORDS),
		.BASE_INDEX (`DBG_IMU_WORDS) // rc indices follow the imu group
	) u_rc_fmt (
		.clk     (clk),
		.resetn  (resetn),
		.load_i  (start_acc),
		.words_i (rc_words_i),
		.chr_o   (rc_chr),
		.vld_o   (rc_vld),
		.crd_i   (rc_crd)
	);

	line_merger u_merger (
		.clk       (clk),
		.resetn    (resetn),
		.imu_chr_i (imu_chr),
		.rc_chr_i  (rc_chr),
		.imu_vld_i (imu_vld),
		.rc_vld_i  (rc_vld),
		.imu_crd_o (imu_crd),
		.rc_crd_o  (rc_crd),
		.tx_chr_o  (tx_chr),
		.tx_vld_o  (tx_vld),
		.tx_crd_i  (tx_crd)
	);

	uart_tx u_tx (
		.clk          (clk),
		.resetn       (resetn),
		.chr_i        (tx_chr),
		.vld_i        (tx_vld),
		.crd_o        (tx_crd),
		.sout_o       (sout_o),
		.frame_done_o (frame_done_o)
	);

endmodule

`default_nettype wire

//--- tb/dbg_uart_assert.sv
// credit link and serial line checks
// bound into the line merger and the uart transmitter
`timescale 1ns/1ns
`default_nettype none

`include "dbg_uart_macros.svh"

module dbg_uart_assert #(
	parameter int NLNK = 1,
	parameter int CW   = $clog2(`DBG_CREDITS + 1)
) (
	input logic                    clk,
	input logic                    resetn,
	input logic [NLNK-1:0]         vld_i,  // character arriving on a link
	input logic [NLNK-1:0][CW-1:0] fill_i, // receive buffer of that link
	input logic [NLNK-1:0]         crd_i,  // credit on its way back to the sender
	input logic                    chk_i,
	input logic                    ok_i    // must be high whenever chk_i is
);

	localparam int DEPTH = `DBG_CREDITS;

	int unsigned fail_cnt = 0;

	// sender credits mirrored as DEPTH minus buffer fill minus returning credit
	for (genvar k = 0; k < NLNK; k++) begin : g_lnk
		a_cnt_range: assert property (@(posedge clk) disable iff (!resetn)
			int'(fill_i[k]) + int'(crd_i[k]) <= DEPTH)
			else begin
				fail_cnt++;
				$error("link %0d sender credit count out of range", k);
			end

		a_vld_credit: assert property (@(posedge clk) disable iff (!resetn)
			vld_i[k] |-> int'(fill_i[k]) + int'(crd_i[k]) < DEPTH)
			else begin
				fail_cnt++;
				$error("link %0d valid asserted with zero credit", k);
			end
	end

	a_state_level: assert property (@(posedge clk) disable iff (!resetn) chk_i |-> ok_i)
		else begin
			fail_cnt++;
			$error("serial line low while idle or imu buffer not drained for the rc group");
		end

endmodule

// rc group starts only once the imu buffer is empty
bind line_merger dbg_uart_assert #(.NLNK(2)) a_merger (
	.clk    (clk),
	.resetn (resetn),
	.vld_i  (in_vld),
	.fill_i ({fill_s[1], fill_s[0]}),
	.crd_i  (crd_q),
	.chk_i  (sel == SRC_RC),
	.ok_i   (fill_s[0] == '0)
);

bind uart_tx dbg_uart_assert #(.NLNK(1)) a_tx (
	.clk    (clk),
	.resetn (resetn),
	.vld_i  (vld_i),
	.fill_i (fill),
	.crd_i  (crd_o),
	.chk_i  (state == TX_IDLE),
	.ok_i   (sout_o)
);

`default_nettype wire

//--- tb/dbg_uart_tb.sv
// debug telemetry uart testbench
// directed frames, decoded from the serial line and compared with the hex line text
`timescale 1ns/1ns
`default_nettype none

`include "dbg_uart_macros.svh"

module dbg_uart_tb import dbg_uart_pkg::*; ();

	localparam int CLK_NS       = 4;
	localparam int CLKS         = `DBG_CLKS_PER_BIT;
	localparam int NWORDS       = `DBG_IMU_WORDS + `DBG_RC_WORDS;
	localparam int NCHARS       = NWORDS * 8;
	localparam int FRAME_CYCLES = NCHARS * 10 * CLKS;
	localparam int FRAMES_RUN   = 6; // fixed, snapshot, busy and three random frames
	localparam int WATCHDOG_NS  = (FRAMES_RUN + 1) * FRAME_CYCLES * CLK_NS;

	logic        clk;
	logic        resetn;
	logic        start;
	imu_vec_t    imu_words;
	rc_vec_t     rc_words;
	logic        sout;
	logic        busy;
	logic        frame_done;

	logic [7:0]  rx_q [$]; // bytes seen on the serial line
	logic [7:0]  exp_text [NCHARS];
	logic [31:0] rng = 32'd83;
	int          checks = 0;
	int          errors = 0;
	int          done_cnt = 0;

	dbg_uart_top dbg_uart_top_i (
		.clk          (clk),
		.resetn       (resetn),
		.start_i      (start),
		.imu_words_i  (imu_words),
		.rc_words_i   (rc_words),
		.sout_o       (sout),
		.busy_o       (busy),
		.frame_done_o (frame_done)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the run did not finish in time");
		$display("Test FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [7:0] hex_digit(input logic [3:0] d);
		if (d < 4'd10)
			return {4'h0, d} + 8'h30; // '0'..'9'
		return {4'h0, d} - 8'd10 + 8'h41; // 'A'..'F'
	endfunction

	// index digits, value digits msb first, LF, CR
	task automatic build_expected(input imu_vec_t imu, input rc_vec_t rc);
		logic [15:0] w;
		logic [7:0]  idx;
		for (int i = 0; i < NWORDS; i++) begin
			idx = 8'(i);
			if (i < `DBG_IMU_WORDS)
				w = imu[i];
			else
				w = rc[i - `DBG_IMU_WORDS];
			exp_text[8 * i + 0] = hex_digit(idx[7:4]);
			exp_text[8 * i + 1] = hex_digit(idx[3:0]);
			exp_text[8 * i + 2] = hex_digit(w[15:12]);
			exp_text[8 * i + 3] = hex_digit(w[11:8]);
			exp_text[8 * i + 4] = hex_digit(w[7:4]);
			exp_text[8 * i + 5] = hex_digit(w[3:0]);
			exp_text[8 * i + 6] = 8'h0A;
			exp_text[8 * i + 7] = 8'h0D;
		end
	endtask

	task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("[FAIL] %0t ns %s expected %0h got %0h", $time, name, want, got);
		end
	endtask

	// samples in the middle of each bit, clock counted
	task automatic decode_char(output logic [7:0] b);
		do
			@(negedge clk);
		while (sout !== 1'b0);
		repeat (CLKS / 2) @(negedge clk);
		assert (sout === 1'b0) else begin
			errors++;
			$display("start bit on the serial line ended too early at %0t ns", $time);
		end
		for (int i = 0; i < 8; i++) begin
			repeat (CLKS) @(negedge clk);
			b[i] = sout;
		end
		repeat (CLKS) @(negedge clk);
		assert (sout === 1'b1) else begin
			errors++;
			$display("stop bit missing on the serial line at %0t ns", $time);
		end
	endtask

	initial begin : serial_rx
		logic [7:0] b;
		wait (resetn === 1'b1);
		forever begin
			decode_char(b);
			rx_q.push_back(b);
		end
	end

	initial begin : done_monitor
		forever begin
			@(negedge clk);
			if (frame_done === 1'b1)
				done_cnt++;
		end
	end

	task automatic launch(input imu_vec_t imu, input rc_vec_t rc);
		@(posedge clk);
		#1;
		imu_words = imu;
		rc_words  = rc;
		start     = 1'b1;
		@(posedge clk); // accepted here
		#1;
		start = 1'b0;
	endtask

	task automatic confirm_busy();
		@(negedge clk);
		expect_eq("busy", busy, 1);
	endtask

	task automatic wait_frame_done();
		bit seen;
		seen = 1'b0;
		for (int n = 0; n < 2 * FRAME_CYCLES && !seen; n++) begin
			@(negedge clk);
			if (frame_done === 1'b1)
				seen = 1'b1;
		end
		assert (seen) else begin
			errors++;
			$display("frame_done did not arrive within %0d cycles", 2 * FRAME_CYCLES);
		end
		expect_eq("busy", busy, 0); // falls with frame_done
	endtask

	task automatic check_text();
		int n;
		n = rx_q.size();
		expect_eq("rx_count", n, NCHARS);
		for (int i = 0; i < NCHARS && i < n; i++)
			expect_eq($sformatf("rx_char[%0d]", i), rx_q[i], exp_text[i]);
	endtask

	task automatic one_frame(input imu_vec_t imu, input rc_vec_t rc, input bit scramble);
		int base;
		build_expected(imu, rc);
		rx_q.delete();
		base = done_cnt;
		launch(imu, rc);
		if (scramble) begin
			imu_words = ~imu; // snapshot already taken
			rc_words  = ~rc;
		end
		confirm_busy();
		wait_frame_done();
		check_text();
		repeat (4) @(negedge clk);
		expect_eq("frame_done_count", done_cnt - base, 1);
		expect_eq("busy", busy, 0);
	endtask

	task automatic idle_after_reset();
		for (int i = 0; i < 50; i++) begin
			@(negedge clk);
			expect_eq("sout", sout, 1);
			expect_eq("busy", busy, 0);
			expect_eq("frame_done", frame_done, 0);
		end
		expect_eq("rx_count", rx_q.size(), 0);
	endtask

	task automatic fixed_frame();
		imu_vec_t imu;
		rc_vec_t  rc;
		for (int i = 0; i < `DBG_IMU_WORDS; i++)
			imu[i] = 16'(16'h0ABC + i * 16'h1111);
		for (int i = 0; i < `DBG_RC_WORDS; i++)
			rc[i] = 16'(16'hFEDC - i * 16'h0123);
		one_frame(imu, rc, 1'b0);
	endtask

	task automatic snapshot_hold();
		imu_vec_t imu;
		rc_vec_t  rc;
		for (int i = 0; i < `DBG_IMU_WORDS; i++)
			imu[i] = 16'(16'h5A00 + i * 16'h0107);
		for (int i = 0; i < `DBG_RC_WORDS; i++)
			rc[i] = 16'(16'hC3F0 ^ (i * 16'h0B0D));
		one_frame(imu, rc, 1'b1);
	endtask

	task automatic starts_while_busy();
		imu_vec_t imu;
		rc_vec_t  rc;
		int       base;
		for (int i = 0; i < `DBG_IMU_WORDS; i++)
			imu[i] = 16'(i * 16'h2345);
		for (int i = 0; i < `DBG_RC_WORDS; i++)
			rc[i] = 16'(16'h8001 + i * 16'h0F0F);
		build_expected(imu, rc);
		rx_q.delete();
		base = done_cnt;
		launch(imu, rc);
		confirm_busy();
		for (int k = 0; k < 3; k++) begin
			repeat (1500) @(posedge clk);
			#1;
			start = 1'b1; // must be ignored
			@(posedge clk);
			#1;
			start = 1'b0;
		end
		wait_frame_done();
		check_text();
		repeat (2 * 10 * CLKS * 8) @(negedge clk); // room for a stray line
		expect_eq("rx_count", rx_q.size(), NCHARS);
		expect_eq("frame_done_count", done_cnt - base, 1);
		expect_eq("busy", busy, 0);
	endtask

	task automatic random_back_to_back();
		imu_vec_t imu;
		rc_vec_t  rc;
		int       base;
		base = done_cnt;
		for (int f = 0; f < 3; f++) begin
			for (int i = 0; i < `DBG_IMU_WORDS; i++) begin
				rng    = xorshift32(rng);
				imu[i] = rng[15:0];
			end
			for (int i = 0; i < `DBG_RC_WORDS; i++) begin
				rng   = xorshift32(rng);
				rc[i] = rng[15:0];
			end
			build_expected(imu, rc);
			rx_q.delete();
			launch(imu, rc);
			confirm_busy();
			wait_frame_done();
			check_text();
			expect_eq("sout", sout, 1); // idle level between frames
		end
		repeat (4) @(negedge clk);
		expect_eq("frame_done_count", done_cnt - base, 3);
	endtask

	initial begin : main
		int asrt_fails;
		resetn    = 1'b0;
		start     = 1'b0;
		imu_words = '0;
		rc_words  = '0;
		repeat (4) @(posedge clk);
		#1;
		resetn = 1'b1;

		idle_after_reset();
		fixed_frame();
		snapshot_hold();
		starts_while_busy();
		random_back_to_back();

		asrt_fails = dbg_uart_top_i.u_merger.a_merger.fail_cnt
			+ dbg_uart_top_i.u_tx.a_tx.fail_cnt;
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors, asrt_fails);
		if (errors == 0 && asrt_fails == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- dbg_uart.f
+incdir+common
common/dbg_uart_pkg.sv
telem_fmt/telem_formatter.sv
verilog/line_merger.sv
uart_tx/uart_tx.sv
verilog/dbg_uart_top.sv
tb/dbg_uart_assert.sv
tb/dbg_uart_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the debug telemetry uart testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module dbg_uart_tb -f dbg_uart.f
./obj_dir/Vdbg_uart_tb > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log
if grep -q "Test FAILED" sim.log; then
	exit 1
fi
exit 0
